//--- src/vxu_settings.svh
/*
 * Vector lane settings
 * Element width, register file geometry and pipeline latencies
 * shared by the package and the lane top level
 */

`ifndef VXU_SETTINGS_SVH
`define VXU_SETTINGS_SVH

// Element width
`define VXU_DATA_WIDTH 32

// Register index width per bank
`define VXU_RF_ADDR_WIDTH 4

// Elements per vector register
`define VXU_NELEMENT 16

// Sequencer element counter
`define VXU_CNT_WIDTH 10

// Bank read and ALU latencies
`define VXU_RF_READ_LAT 1
`define VXU_ALU_LAT 2

// Issue to write-back
`define VXU_LANE_LAT (`VXU_RF_READ_LAT + `VXU_ALU_LAT)

`endif

//--- src/vxu_pkg.sv
/*
 * Vector lane types
 * Command, bank port, operand select and pipeline control structures
 */

`include "vxu_settings.svh"

package vxu_pkg;

    localparam int OFS_W = $clog2(`VXU_NELEMENT);
    localparam int RF_AW = `VXU_RF_ADDR_WIDTH + OFS_W;

    typedef logic [`VXU_DATA_WIDTH-1:0] data_t;
    typedef logic [`VXU_RF_ADDR_WIDTH-1:0] rf_idx_t;
    typedef logic [OFS_W-1:0] ofs_t;
    // Register index over element offset
    typedef logic [RF_AW-1:0] rf_addr_t;

    typedef struct packed {
        logic    en;
        rf_idx_t idx;
    } rf_port_t;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_MUL  = 3'd2,
        ALU_SADD = 3'd3,
        ALU_SMUL = 3'd4
    } alu_op_e;

    typedef enum logic [1:0] {
        WSRC_NONE = 2'd0,
        WSRC_ALU  = 2'd1,
        WSRC_SPM  = 2'd2
    } wsrc_e;

    // Bank select per read-side consumer, 1 picks bank1
    typedef struct packed {
        logic opa_bank;
        logic opb_bank;
        logic store_bank;
    } mux_o_t;

    typedef struct packed {
        rf_port_t bk0_r;
        rf_port_t bk0_w;
        rf_port_t bk1_r;
        rf_port_t bk1_w;
        alu_op_e  alu_op;
        data_t    scalar;
        mux_o_t   mux_o;
        wsrc_e    bk0_wsrc;
        wsrc_e    bk1_wsrc;
    } vxu_cmd_t;

    typedef struct packed {
        logic     valid;
        rf_port_t bk0_w;
        rf_port_t bk1_w;
        wsrc_e    bk0_wsrc;
        wsrc_e    bk1_wsrc;
        ofs_t     ofs;
    } wb_ctl_t;

    // Controls needed once the bank read data arrives
    typedef struct packed {
        logic    valid;
        alu_op_e alu_op;
        data_t   scalar;
        mux_o_t  mux_o;
    } rd_ctl_t;

endpackage

//--- src/vxu_cmd_latch.sv
/*
 * Command latch
 * Holds the issued command between elements and exchanges the read
 * and write ports of both banks when the sequencer toggles its swap flag
 */

`timescale 1ns/10ps

module vxu_cmd_latch
    import vxu_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     i_op_vld,
    input  logic     i_comp_vld,
    input  logic     i_rw_swap,
    input  vxu_cmd_t i_cmd,
    output vxu_cmd_t o_cmd
);

    vxu_cmd_t cmd_q;
    vxu_cmd_t cmd_swapped;
    logic     swap_q;
    logic     swap_req;

    // Flag toggled by the sequencer since the last command or swap
    assign swap_req = i_comp_vld && (i_rw_swap != swap_q);

    always_comb begin
        cmd_swapped       = cmd_q;
        cmd_swapped.bk0_r = cmd_q.bk0_w;
        cmd_swapped.bk0_w = cmd_q.bk0_r;
        cmd_swapped.bk1_r = cmd_q.bk1_w;
        cmd_swapped.bk1_w = cmd_q.bk1_r;
    end

    // A new command takes priority over a pending swap
    always_comb begin
        if (i_op_vld) begin
            o_cmd = i_cmd;
        end
        else if (swap_req) begin
            o_cmd = cmd_swapped;
        end
        else begin
            o_cmd = cmd_q;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_q  <= '0;
            swap_q <= 1'b0;
        end
        else if (i_op_vld) begin
            cmd_q  <= i_cmd;
            swap_q <= i_rw_swap;
        end
        else if (swap_req) begin
            // Swapped form stays until the next toggle
            cmd_q  <= cmd_swapped;
            swap_q <= i_rw_swap;
        end
    end

endmodule

//--- src/vxu_rf_bank.sv
/*
 * Register file bank
 * One bank of vector registers with a single registered read port
 * and a single write port
 */

`timescale 1ns/10ps

module vxu_rf_bank
    import vxu_pkg::*;
(
    input  logic     clk,
    input  logic     i_re,
    input  rf_addr_t i_raddr,
    input  logic     i_we,
    input  rf_addr_t i_waddr,
    input  data_t    i_wdata,
    output data_t    o_rdata
);

    // Registers times elements
    data_t mem [2**RF_AW];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // Same-edge write is not visible to the read
    always_ff @(posedge clk) begin
        if (i_re) begin
            o_rdata <= mem[i_raddr];
        end
    end

endmodule

//--- src/vxu_delay_line.sv
/*
 * Delay line
 * Carries a payload of any type through DEPTH register stages
 */

`timescale 1ns/10ps

module vxu_delay_line #(
    parameter type T     = logic,
    parameter int  DEPTH = 1
) (
    input  logic clk,
    input  logic rst_n,
    input  T     i_data,
    output T     o_data
);

    T stage_q [DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end
        else begin
            stage_q[0] <= i_data;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign o_data = stage_q[DEPTH-1];

endmodule

//--- src/vxu_mod_alu.sv
/*
 * Modular ALU
 * Two-stage add, subtract and multiply modulo q, vector or scalar
 * second operand, operands below q
 */

`timescale 1ns/10ps

module vxu_mod_alu
    import vxu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    i_valid,
    input  alu_op_e i_op,
    input  data_t   i_opa,
    input  data_t   i_opb,
    input  data_t   i_scalar,
    input  data_t   i_mod,
    output data_t   o_res
);

    localparam int W = $bits(data_t);

    typedef logic [2*W-1:0] wide_t;

    data_t opb_sel;
    wide_t wide_d;
    logic  is_mul_d;
    wide_t wide_q;
    logic  is_mul_q;
    data_t mod_r;
    logic  vld_q;

    assign opb_sel  = (i_op == ALU_SADD || i_op == ALU_SMUL) ? i_scalar : i_opb;
    assign is_mul_d = (i_op == ALU_MUL || i_op == ALU_SMUL);

    ////////////////////////////////////////////////////////////
    // Stage 1, unreduced value
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (i_op)
            ALU_ADD, ALU_SADD: wide_d = wide_t'(i_opa) + wide_t'(opb_sel);
            // Biased by q so the result stays positive
            ALU_SUB:           wide_d = wide_t'(i_opa) + wide_t'(i_mod) - wide_t'(opb_sel);
            ALU_MUL, ALU_SMUL: wide_d = wide_t'(i_opa) * wide_t'(opb_sel);
            default:           wide_d = wide_t'(i_opa);
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end
        else begin
            vld_q <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            wide_q   <= wide_d;
            is_mul_q <= is_mul_d;
            mod_r    <= i_mod;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 2, reduction
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (vld_q) begin
            if (is_mul_q) begin
                o_res <= data_t'(wide_q % wide_t'(mod_r));
            end
            else if (wide_q >= wide_t'(mod_r)) begin
                // Sums stay below 2q
                o_res <= data_t'(wide_q - wide_t'(mod_r));
            end
            else begin
                o_res <= data_t'(wide_q);
            end
        end
    end

endmodule

//--- src/vxu_lane.sv
/*
 * Vector lane
 * Two register banks, a modular ALU and the SPM load/store path,
 * driven element by element from the sequencer. Results and SPM data
 * are written back a fixed number of cycles after issue
 */

`timescale 1ns/10ps

`include "vxu_settings.svh"

module vxu_lane
    import vxu_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_op_vld,
    input  vxu_cmd_t                  i_cmd,
    input  logic                      i_comp_vld,
    input  logic [`VXU_CNT_WIDTH-1:0] i_cnt,
    input  logic                      i_rw_swap,
    input  data_t                     i_vp_data,
    input  data_t                     i_mod_q,
    input  logic                      i_mod_q_we,
    output data_t                     o_vp_data
);

    vxu_cmd_t cmd;
    data_t    mod_q;
    logic     issue;
    ofs_t     ofs;
    wb_ctl_t  wb_ctl_in;
    wb_ctl_t  wb_ctl_d;
    rd_ctl_t  rd_ctl_in;
    rd_ctl_t  rd_ctl_d;
    data_t    spm_d;
    data_t    bk0_rdata;
    data_t    bk1_rdata;
    data_t    opa;
    data_t    opb;
    data_t    store_sel;
    data_t    store_q [`VXU_ALU_LAT];
    data_t    alu_res;
    logic     bk0_we;
    logic     bk1_we;
    data_t    bk0_wdata;
    data_t    bk1_wdata;

    ////////////////////////////////////////////////////////////
    // Issue
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_mod_q_we) begin
            mod_q <= i_mod_q;
        end
    end

    vxu_cmd_latch u_cmd_latch (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_op_vld   (i_op_vld),
        .i_comp_vld (i_comp_vld),
        .i_rw_swap  (i_rw_swap),
        .i_cmd      (i_cmd),
        .o_cmd      (cmd)
    );

    // Config write steals the element slot
    assign issue = i_comp_vld && !i_mod_q_we;
    assign ofs   = i_cnt[OFS_W-1:0];

    assign wb_ctl_in = '{valid: issue, bk0_w: cmd.bk0_w, bk1_w: cmd.bk1_w,
                         bk0_wsrc: cmd.bk0_wsrc, bk1_wsrc: cmd.bk1_wsrc, ofs: ofs};
    assign rd_ctl_in = '{valid: issue, alu_op: cmd.alu_op, scalar: cmd.scalar,
                         mux_o: cmd.mux_o};

    vxu_rf_bank u_bank0 (
        .clk     (clk),
        .i_re    (issue && cmd.bk0_r.en),
        .i_raddr ({cmd.bk0_r.idx, ofs}),
        .i_we    (bk0_we),
        .i_waddr ({wb_ctl_d.bk0_w.idx, wb_ctl_d.ofs}),
        .i_wdata (bk0_wdata),
        .o_rdata (bk0_rdata)
    );

    vxu_rf_bank u_bank1 (
        .clk     (clk),
        .i_re    (issue && cmd.bk1_r.en),
        .i_raddr ({cmd.bk1_r.idx, ofs}),
        .i_we    (bk1_we),
        .i_waddr ({wb_ctl_d.bk1_w.idx, wb_ctl_d.ofs}),
        .i_wdata (bk1_wdata),
        .o_rdata (bk1_rdata)
    );

    vxu_delay_line #(.T(wb_ctl_t), .DEPTH(`VXU_LANE_LAT)) u_wb_pipe (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_data (wb_ctl_in),
        .o_data (wb_ctl_d)
    );

    vxu_delay_line #(.T(data_t), .DEPTH(`VXU_LANE_LAT)) u_spm_pipe (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_data (i_vp_data),
        .o_data (spm_d)
    );

    vxu_delay_line #(.T(rd_ctl_t), .DEPTH(`VXU_RF_READ_LAT)) u_rd_pipe (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_data (rd_ctl_in),
        .o_data (rd_ctl_d)
    );

    ////////////////////////////////////////////////////////////
    // Operand select and ALU
    ////////////////////////////////////////////////////////////

    assign opa       = rd_ctl_d.mux_o.opa_bank   ? bk1_rdata : bk0_rdata;
    assign opb       = rd_ctl_d.mux_o.opb_bank   ? bk1_rdata : bk0_rdata;
    assign store_sel = rd_ctl_d.mux_o.store_bank ? bk1_rdata : bk0_rdata;

    vxu_mod_alu u_alu (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_valid  (rd_ctl_d.valid),
        .i_op     (rd_ctl_d.alu_op),
        .i_opa    (opa),
        .i_opb    (opb),
        .i_scalar (rd_ctl_d.scalar),
        .i_mod    (mod_q),
        .o_res    (alu_res)
    );

    // Store data waits alongside the ALU
    always_ff @(posedge clk) begin
        store_q[0] <= store_sel;
        for (int i = 1; i < `VXU_ALU_LAT; i++) begin
            store_q[i] <= store_q[i-1];
        end
    end

    ////////////////////////////////////////////////////////////
    // Write-back
    ////////////////////////////////////////////////////////////

    assign bk0_we = wb_ctl_d.valid && wb_ctl_d.bk0_w.en && (wb_ctl_d.bk0_wsrc != WSRC_NONE);
    assign bk1_we = wb_ctl_d.valid && wb_ctl_d.bk1_w.en && (wb_ctl_d.bk1_wsrc != WSRC_NONE);

    assign bk0_wdata = (wb_ctl_d.bk0_wsrc == WSRC_SPM) ? spm_d : alu_res;
    assign bk1_wdata = (wb_ctl_d.bk1_wsrc == WSRC_SPM) ? spm_d : alu_res;

    // SPM output updates on the same edge as the bank write
    always_ff @(posedge clk) begin
        if (wb_ctl_d.valid) begin
            o_vp_data <= store_q[`VXU_ALU_LAT-1];
        end
    end

endmodule

//--- testbench/vxu_lane_monitor.sv
/*
 * Lane monitor
 * Reference model of the command latch and both banks, predicts
 * o_vp_data for store elements and counts mismatches
 */

`timescale 1ns/10ps

`include "vxu_settings.svh"

module vxu_lane_monitor
    import vxu_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      i_op_vld,
    input  vxu_cmd_t                  i_cmd,
    input  logic                      i_comp_vld,
    input  logic [`VXU_CNT_WIDTH-1:0] i_cnt,
    input  logic                      i_rw_swap,
    input  data_t                     i_vp_data,
    input  data_t                     i_mod_q,
    input  logic                      i_mod_q_we,
    input  data_t                     i_vp_out,
    output int                        o_checks,
    output int                        o_errors
);

    typedef struct packed {
        logic [31:0] due;
        logic        bank;
        rf_addr_t    addr;
        data_t       data;
    } wr_t;

    typedef struct packed {
        logic [31:0] due;
        data_t       data;
    } exp_t;

    data_t       mem0 [2**RF_AW];
    data_t       mem1 [2**RF_AW];
    vxu_cmd_t    lat_cmd;
    logic        lat_swap;
    data_t       mod_m;
    data_t       rd0;
    data_t       rd1;
    logic [31:0] cyc;
    wr_t         wr_q [$];
    exp_t        exp_q [$];

    initial begin
        o_checks = 0;
        o_errors = 0;
    end

    // Read and write ports of both banks trade places
    function automatic vxu_cmd_t swap_ports(input vxu_cmd_t c);
        vxu_cmd_t s;
        s       = c;
        s.bk0_r = c.bk0_w;
        s.bk0_w = c.bk0_r;
        s.bk1_r = c.bk1_w;
        s.bk1_w = c.bk1_r;
        return s;
    endfunction

    function automatic data_t mod_apply(input alu_op_e op, input data_t a, input data_t b,
                                        input data_t s, input data_t q);
        logic [63:0] x;
        case (op)
            ALU_ADD:  x = (64'(a) + 64'(b)) % 64'(q);
            ALU_SUB:  x = (64'(a) + 64'(q) - 64'(b)) % 64'(q);
            ALU_MUL:  x = (64'(a) * 64'(b)) % 64'(q);
            ALU_SADD: x = (64'(a) + 64'(s)) % 64'(q);
            default:  x = (64'(a) * 64'(s)) % 64'(q);
        endcase
        return x[31:0];
    endfunction

    ////////////////////////////////////////////////////////////
    // Issue side model
    ////////////////////////////////////////////////////////////

    always @(posedge clk or negedge rst_n) begin : model
        vxu_cmd_t eff;
        ofs_t     ofs;
        data_t    opa;
        data_t    opb;
        data_t    res;
        wr_t      w;
        if (!rst_n) begin
            lat_cmd  = '0;
            lat_swap = 1'b0;
            cyc      = '0;
        end
        else begin
            cyc = cyc + 1;
            if (i_op_vld) begin
                eff      = i_cmd;
                lat_cmd  = i_cmd;
                lat_swap = i_rw_swap;
            end
            else if (i_comp_vld && (i_rw_swap != lat_swap)) begin
                eff      = swap_ports(lat_cmd);
                lat_cmd  = eff;
                lat_swap = i_rw_swap;
            end
            else begin
                eff = lat_cmd;
            end
            if (i_mod_q_we) begin
                mod_m = i_mod_q;
            end
            if (i_comp_vld && !i_mod_q_we) begin
                ofs = i_cnt[OFS_W-1:0];
                if (eff.bk0_r.en) begin
                    rd0 = mem0[{eff.bk0_r.idx, ofs}];
                end
                if (eff.bk1_r.en) begin
                    rd1 = mem1[{eff.bk1_r.idx, ofs}];
                end
                opa = eff.mux_o.opa_bank ? rd1 : rd0;
                opb = eff.mux_o.opb_bank ? rd1 : rd0;
                res = mod_apply(eff.alu_op, opa, opb, eff.scalar, mod_m);
                if (eff.bk0_w.en && eff.bk0_wsrc != WSRC_NONE) begin
                    wr_q.push_back('{cyc + 3, 1'b0, {eff.bk0_w.idx, ofs},
                                     (eff.bk0_wsrc == WSRC_SPM) ? i_vp_data : res});
                end
                if (eff.bk1_w.en && eff.bk1_wsrc != WSRC_NONE) begin
                    wr_q.push_back('{cyc + 3, 1'b1, {eff.bk1_w.idx, ofs},
                                     (eff.bk1_wsrc == WSRC_SPM) ? i_vp_data : res});
                end
                // Pure store element
                if (eff.bk0_wsrc == WSRC_NONE && eff.bk1_wsrc == WSRC_NONE) begin
                    exp_q.push_back('{cyc + 3, eff.mux_o.store_bank ? rd1 : rd0});
                end
            end
            // Writes land after the reads of the same edge
            while (wr_q.size() > 0 && wr_q[0].due == cyc) begin
                w = wr_q.pop_front();
                if (w.bank) begin
                    mem1[w.addr] = w.data;
                end
                else begin
                    mem0[w.addr] = w.data;
                end
            end
        end
    end

    always @(negedge clk) begin : compare
        exp_t e;
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            e        = exp_q.pop_front();
            o_checks = o_checks + 1;
            if (i_vp_out !== e.data) begin
                o_errors = o_errors + 1;
                $display("CHECK FAILED o_vp_data: expected %h, got %h at %0t",
                         e.data, i_vp_out, $time);
            end
        end
    end

endmodule

//--- testbench/vxu_lane_chk.sv
/*
 * Lane assertions
 * Write-back gating, config-write slot stealing and ALU result range
 */

`timescale 1ns/10ps

`include "vxu_settings.svh"

module vxu_lane_chk
    import vxu_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  i_comp_vld,
    input  logic  i_mod_q_we,
    input  logic  i_wb_valid,
    input  logic  i_bk0_we,
    input  logic  i_bk1_we,
    input  wsrc_e i_bk0_wsrc,
    input  wsrc_e i_bk1_wsrc,
    input  data_t i_alu_res,
    input  data_t i_mod
);

    int fail_cnt = 0;

    // A bank write needs an element that entered the pipe a lane latency earlier
    a_wb_gated: assert property (@(posedge clk) disable iff (!rst_n)
        (i_bk0_we || i_bk1_we) |-> $past(i_comp_vld, `VXU_LANE_LAT))
        else begin
            fail_cnt++;
            $error("bank written with no element issued a lane latency earlier");
        end

    a_cfg_steals_slot: assert property (@(posedge clk) disable iff (!rst_n)
        i_mod_q_we |-> ##`VXU_LANE_LAT !(i_bk0_we || i_bk1_we))
        else begin
            fail_cnt++;
            $error("element issued in a modulus write cycle reached the banks");
        end

    // Modulus seen by the ALU two edges before write-back
    a_res_below_q: assert property (@(posedge clk) disable iff (!rst_n)
        (i_wb_valid && ((i_bk0_we && i_bk0_wsrc == WSRC_ALU) ||
                        (i_bk1_we && i_bk1_wsrc == WSRC_ALU)))
        |-> (i_alu_res < $past(i_mod, 2)))
        else begin
            fail_cnt++;
            $error("ALU result not below the modulus");
        end

endmodule

bind vxu_lane vxu_lane_chk chk0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_comp_vld (i_comp_vld),
    .i_mod_q_we (i_mod_q_we),
    .i_wb_valid (wb_ctl_d.valid),
    .i_bk0_we   (bk0_we),
    .i_bk1_we   (bk1_we),
    .i_bk0_wsrc (wb_ctl_d.bk0_wsrc),
    .i_bk1_wsrc (wb_ctl_d.bk1_wsrc),
    .i_alu_res  (alu_res),
    .i_mod      (mod_q)
);

//--- testbench/tb_vxu_lane.sv
/*
 * Vector lane testbench
 * Applies a table of load, store and ALU phases to the lane and
 * reports the monitor's comparison counts
 */

`timescale 1ns/10ps

`include "vxu_settings.svh"

module tb_vxu_lane
    import vxu_pkg::*;
();

    localparam data_t Q_INIT = 32'h7fff_ffed;
    localparam int    CW     = `VXU_CNT_WIDTH;

    typedef struct {
        string    name;
        vxu_cmd_t cmd;
        int       count;
        data_t    mask;
        int       mod_elem;
        data_t    mod_val;
        int       swap_at;
    } phase_t;

    logic                      clk;
    logic                      rst_n;
    logic                      i_op_vld;
    vxu_cmd_t                  i_cmd;
    logic                      i_comp_vld;
    logic [`VXU_CNT_WIDTH-1:0] i_cnt;
    logic                      i_rw_swap;
    data_t                     i_vp_data;
    data_t                     i_mod_q;
    logic                      i_mod_q_we;
    data_t                     o_vp_data;
    int                        checks;
    int                        errors;

    phase_t phases [$];
    integer seed;
    data_t  q_cur;
    logic   swap_lvl;
    int     wd_cycles;
    logic   table_ready;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    vxu_lane dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_op_vld   (i_op_vld),
        .i_cmd      (i_cmd),
        .i_comp_vld (i_comp_vld),
        .i_cnt      (i_cnt),
        .i_rw_swap  (i_rw_swap),
        .i_vp_data  (i_vp_data),
        .i_mod_q    (i_mod_q),
        .i_mod_q_we (i_mod_q_we),
        .o_vp_data  (o_vp_data)
    );

    vxu_lane_monitor mon0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_op_vld   (i_op_vld),
        .i_cmd      (i_cmd),
        .i_comp_vld (i_comp_vld),
        .i_cnt      (i_cnt),
        .i_rw_swap  (i_rw_swap),
        .i_vp_data  (i_vp_data),
        .i_mod_q    (i_mod_q),
        .i_mod_q_we (i_mod_q_we),
        .i_vp_out   (o_vp_data),
        .o_checks   (checks),
        .o_errors   (errors)
    );

    ////////////////////////////////////////////////////////////
    // Command builders and phase table
    ////////////////////////////////////////////////////////////

    function automatic vxu_cmd_t load_cmd(input logic bank, input rf_idx_t idx);
        vxu_cmd_t c;
        c = '0;
        if (bank) begin
            c.bk1_w    = {1'b1, idx};
            c.bk1_wsrc = WSRC_SPM;
        end
        else begin
            c.bk0_w    = {1'b1, idx};
            c.bk0_wsrc = WSRC_SPM;
        end
        return c;
    endfunction

    function automatic vxu_cmd_t store_cmd(input logic bank, input rf_idx_t idx);
        vxu_cmd_t c;
        c = '0;
        if (bank) begin
            c.bk1_r            = {1'b1, idx};
            c.mux_o.store_bank = 1'b1;
        end
        else begin
            c.bk0_r = {1'b1, idx};
        end
        return c;
    endfunction

    function automatic vxu_cmd_t alu_cmd(input alu_op_e op, input rf_port_t r0,
                                         input rf_port_t r1, input mux_o_t mux,
                                         input logic wbank, input rf_idx_t widx,
                                         input data_t scalar);
        vxu_cmd_t c;
        c        = '0;
        c.bk0_r  = r0;
        c.bk1_r  = r1;
        c.alu_op = op;
        c.mux_o  = mux;
        c.scalar = scalar;
        if (wbank) begin
            c.bk1_w    = {1'b1, widx};
            c.bk1_wsrc = WSRC_ALU;
        end
        else begin
            c.bk0_w    = {1'b1, widx};
            c.bk0_wsrc = WSRC_ALU;
        end
        return c;
    endfunction

    task automatic add_phase(input string name, input vxu_cmd_t cmd, input int count,
                             input data_t mask, input int mod_elem, input data_t mod_val,
                             input int swap_at);
        phase_t p;
        p.name     = name;
        p.cmd      = cmd;
        p.count    = count;
        p.mask     = mask;
        p.mod_elem = mod_elem;
        p.mod_val  = mod_val;
        p.swap_at  = swap_at;
        phases.push_back(p);
    endtask

    // Port literals are {en, idx}, mux literals {opa, opb, store}
    task automatic build_table();
        add_phase("ld_b0_r1", load_cmd(0, 1), 16, 32'h0, -1, 0, -1);
        add_phase("ld_b1_r2", load_cmd(1, 2), 16, 32'h7fff_0000, -1, 0, -1);
        add_phase("st_b0_r1", store_cmd(0, 1), 16, 0, -1, 0, -1);
        add_phase("st_b1_r2", store_cmd(1, 2), 16, 0, -1, 0, -1);
        add_phase("add_vv", alu_cmd(ALU_ADD, 5'h11, 5'h12, 3'b010, 0, 3, 0), 16, 0, -1, 0, -1);
        add_phase("st_add", store_cmd(0, 3), 16, 0, -1, 0, -1);
        add_phase("sub_vv", alu_cmd(ALU_SUB, 5'h11, 5'h12, 3'b010, 0, 3, 0), 16, 0, -1, 0, -1);
        add_phase("st_sub", store_cmd(0, 3), 16, 0, -1, 0, -1);
        add_phase("mul_vv", alu_cmd(ALU_MUL, 5'h11, 5'h12, 3'b010, 0, 3, 0), 16, 0, -1, 0, -1);
        add_phase("st_mul", store_cmd(0, 3), 16, 0, -1, 0, -1);
        add_phase("sadd", alu_cmd(ALU_SADD, 5'h11, 5'h00, 3'b000, 1, 4, 32'h7fff_0123),
                  16, 0, -1, 0, -1);
        add_phase("st_sadd", store_cmd(1, 4), 16, 0, -1, 0, -1);
        add_phase("smul", alu_cmd(ALU_SMUL, 5'h11, 5'h00, 3'b000, 1, 5, 32'h1234_5678),
                  16, 0, -1, 0, -1);
        add_phase("st_smul", store_cmd(1, 5), 16, 0, -1, 0, -1);
        add_phase("swap", alu_cmd(ALU_SADD, 5'h11, 5'h00, 3'b000, 0, 3, 5), 16, 0, -1, 0, 8);
        add_phase("st_swap_r1", store_cmd(0, 1), 16, 0, -1, 0, -1);
        add_phase("st_swap_r3", store_cmd(0, 3), 16, 0, -1, 0, -1);
        add_phase("modwe", alu_cmd(ALU_SADD, 5'h11, 5'h00, 3'b000, 0, 3, 32'h7fff_0000),
                  16, 0, 5, 32'hffff_fffb, -1);
        add_phase("st_modwe", store_cmd(0, 3), 16, 0, -1, 0, -1);
        add_phase("add_newq", alu_cmd(ALU_ADD, 5'h11, 5'h12, 3'b010, 1, 7, 0), 16, 0, -1, 0, -1);
        add_phase("st_newq", store_cmd(1, 7), 16, 0, -1, 0, -1);
    endtask

    ////////////////////////////////////////////////////////////
    // Driver
    ////////////////////////////////////////////////////////////

    function automatic data_t spm_word(input data_t mask);
        data_t r;
        r = $random(seed);
        return (r | mask) % q_cur;
    endfunction

    task automatic drive_idle();
        i_op_vld   = 1'b0;
        i_comp_vld = 1'b0;
        i_mod_q_we = 1'b0;
    endtask

    task automatic run_phase(input phase_t p);
        for (int e = 0; e < p.count; e++) begin
            @(negedge clk);
            if (e == p.swap_at) begin
                swap_lvl = ~swap_lvl;
            end
            i_op_vld   = (e == 0);
            i_cmd      = p.cmd;
            i_comp_vld = 1'b1;
            i_cnt      = CW'(e);
            i_rw_swap  = swap_lvl;
            i_vp_data  = spm_word(p.mask);
            i_mod_q_we = (e == p.mod_elem);
            i_mod_q    = p.mod_val;
            if (e == p.mod_elem) begin
                q_cur = p.mod_val;
            end
        end
        repeat (4) begin
            @(negedge clk);
            drive_idle();
        end
        @(posedge clk);
    endtask

    initial begin : main
        int c0;
        int e0;
        int fails;
        rst_n       = 1'b0;
        i_op_vld    = 1'b0;
        i_cmd       = '0;
        i_comp_vld  = 1'b0;
        i_cnt       = '0;
        i_rw_swap   = 1'b0;
        i_vp_data   = '0;
        i_mod_q     = '0;
        i_mod_q_we  = 1'b0;
        seed        = 32'h9d59_a97b;
        swap_lvl    = 1'b0;
        q_cur       = Q_INIT;
        table_ready = 1'b0;
        build_table();
        wd_cycles = 3;
        foreach (phases[i]) begin
            wd_cycles += 2 * (phases[i].count + 4);
        end
        table_ready = 1'b1;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        // Starting modulus
        @(negedge clk);
        i_mod_q    = Q_INIT;
        i_mod_q_we = 1'b1;
        @(negedge clk);
        i_mod_q_we = 1'b0;
        foreach (phases[i]) begin
            c0 = checks;
            e0 = errors;
            run_phase(phases[i]);
            $display("phase %0d %s: %0d checks, %0d errors", i, phases[i].name,
                     checks - c0, errors - e0);
        end
        fails = dut0.chk0.fail_cnt;
        $display("total: %0d checks, %0d mismatches, %0d assertion failures",
                 checks, errors, fails);
        if (errors == 0 && fails == 0 && checks > 0) begin
            $display("=== PASS ===");
        end
        else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : watchdog
        wait (table_ready);
        repeat (wd_cycles) @(posedge clk);
        $display("Timeout: the phase table did not finish within %0d cycles", wd_cycles);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+src
src/vxu_pkg.sv
src/vxu_cmd_latch.sv
src/vxu_rf_bank.sv
src/vxu_delay_line.sv
src/vxu_mod_alu.sv
src/vxu_lane.sv
testbench/vxu_lane_monitor.sv
testbench/vxu_lane_chk.sv
testbench/tb_vxu_lane.sv
